/* compile.f */
+incdir+hdl
hdl/pool_pkg.sv
hdl/strobe_fifo.sv
hdl/map_arbiter.sv
hdl/max_accum.sv
hdl/pool_core.sv
hdl/pool_top.sv
sim/tb_pool_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pooling engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f compile.f --top-module tb_pool_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pool_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

/* sim/tb_pool_top.sv */
// Directed testbench for pool_top, with map and feature memory models
// Expected maxima come from the map and feature contents, checked per output write
`timescale 1ns/1ps
`include "pool_consts.svh"

module tb_pool_top import pool_pkg::*; ();

    localparam int MAP_AW  = 10;
    localparam int FEAT_AW = 8;

    typedef logic [`IDX_W-1:0]   idx_t;
    typedef logic [`POINT_W-1:0] point_t;
    typedef logic [`K_W-1:0]     k_t;

    // DUT ports
    logic                   clk     = 1'b0;
    logic                   rst_n   = 1'b0;
    logic [`POOL_CORES-1:0] cfg_vld = '0;
    pool_cfg_t              cfg     [`POOL_CORES] = '{default: '0};
    logic [`POOL_CORES-1:0] busy;
    map_req_t               map_rd;
    map_rsp_t               map_rsp = '0;
    ofm_req_t               ofm_rd  [`POOL_CORES];
    ofm_rsp_t               ofm_rsp [`POOL_CORES] = '{default: '0};
    ofm_wr_t                ofm_wr  [`POOL_CORES];

    // Memory contents
    idx_t        map_mem  [2**MAP_AW];
    act_vec_t    feat_mem [2**FEAT_AW];
    logic [31:0] lcg_state = 32'h7f62_ced7;

    // Model state, owned by the model process
    int       cyc          = 0;
    idx_t     map_addr_q   [$];
    int       map_due_q    [$];
    int       map_last_due = 0;
    logic     feat_pend    [`POOL_CORES] = '{default: 1'b0};
    idx_t     feat_addr    [`POOL_CORES];
    int       feat_due     [`POOL_CORES];
    // Captured output writes, in arrival order
    int       wr_core_q    [$];
    idx_t     wr_addr_q    [$];
    act_vec_t wr_vec_q     [$];
    int       last_wr_cyc  [`POOL_CORES] = '{default: 0};

    int err_cnt        = 0;
    int check_cnt      = 0;
    int test_cnt       = 0;
    int test_fail_cnt  = 0;
    int test_err_start = 0;
    int idle_cyc       = 0;

    pool_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_vld (cfg_vld),
        .cfg     (cfg),
        .busy    (busy),
        .map_rd  (map_rd),
        .map_rsp (map_rsp),
        .ofm_rd  (ofm_rd),
        .ofm_rsp (ofm_rsp),
        .ofm_wr  (ofm_wr)
    );

    always #4 clk = ~clk;

    // LCG, numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ======================================================================
    // Reporting and checks
    // ======================================================================
    task automatic note_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_vec(input string name, input act_vec_t got, input act_vec_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input idx_t got, input idx_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = err_cnt - test_err_start;
        test_cnt++;
        if (n == 0) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("test %0d %s: FAIL, %0d errors", test_cnt, name, n);
        end
        test_err_start = err_cnt;
    endtask

    // ======================================================================
    // Memory models and write monitor
    // ======================================================================
    always begin : mem_models
        int   lat;
        int   due;
        idx_t a;
        @(posedge clk);
        cyc = cyc + 1;
        #1;
        // Map answers strictly in request order
        map_rsp = '0;
        if (map_due_q.size() > 0 && map_due_q[0] <= cyc) begin
            a = map_addr_q.pop_front();
            map_due_q.delete(0);
            map_rsp.vld = 1'b1;
            map_rsp.idx = map_mem[a[MAP_AW-1:0]];
        end
        for (int c = 0; c < `POOL_CORES; c++) begin
            ofm_rsp[c] = '0;
            if (feat_pend[c] && feat_due[c] <= cyc) begin
                ofm_rsp[c].vld = 1'b1;
                ofm_rsp[c].vec = feat_mem[feat_addr[c][FEAT_AW-1:0]];
                feat_pend[c]   = 1'b0;
            end
        end
        // Mid-cycle sampling, outputs settled
        @(negedge clk);
        if (rst_n) begin
            if (map_rd.vld) begin
                lat = 1 + int'((next_rand() >> 16) % 32'd5);
                due = cyc + lat;
                // One response per cycle keeps the order
                if (due <= map_last_due) begin
                    due = map_last_due + 1;
                end
                map_last_due = due;
                map_addr_q.push_back(map_rd.addr);
                map_due_q.push_back(due);
            end
            for (int c = 0; c < `POOL_CORES; c++) begin
                if (ofm_rd[c].vld) begin
                    if (feat_pend[c]) begin
                        note_error($sformatf("core %0d read a feature with one pending", c));
                    end
                    lat          = 1 + int'((next_rand() >> 16) % 32'd4);
                    feat_pend[c] = 1'b1;
                    feat_addr[c] = ofm_rd[c].addr;
                    feat_due[c]  = cyc + lat;
                end
                if (ofm_wr[c].vld) begin
                    wr_core_q.push_back(c);
                    wr_addr_q.push_back(ofm_wr[c].addr);
                    wr_vec_q.push_back(ofm_wr[c].vec);
                    last_wr_cyc[c] = cyc;
                end
            end
        end
    end

    // ======================================================================
    // Reference model and test helpers
    // ======================================================================
    function automatic pool_cfg_t make_cfg(input int n, input int k, input int map_base,
                                           input int out_base);
        pool_cfg_t c;
        c.num_points = point_t'(n);
        c.k          = k_t'(k);
        c.map_base   = idx_t'(map_base);
        c.out_base   = idx_t'(out_base);
        return c;
    endfunction

    // Max over the K features named at map_base + p*K + j
    function automatic act_vec_t ref_max(input pool_cfg_t c, input int p);
        act_vec_t res;
        act_vec_t v;
        idx_t     a;
        idx_t     idx;
        res = '0;
        for (int j = 0; j < int'(c.k); j++) begin
            a   = c.map_base + idx_t'(p * int'(c.k) + j);
            idx = map_mem[a[MAP_AW-1:0]];
            v   = feat_mem[idx[FEAT_AW-1:0]];
            for (int l = 0; l < `POOL_LANES; l++) begin
                if (v[l] > res[l]) begin
                    res[l] = v[l];
                end
            end
        end
        return res;
    endfunction

    task automatic start_job(input logic [`POOL_CORES-1:0] mask, input pool_cfg_t c0,
                             input pool_cfg_t c1);
        @(posedge clk);
        #1;
        // A core still stuck from an earlier job gets no new one
        if ((mask & busy) != '0) begin
            note_error($sformatf("job offered to busy cores, mask %h", mask & busy));
        end
        cfg_vld = mask & ~busy;
        cfg[0]  = c0;
        cfg[1]  = c1;
        @(posedge clk);
        #1;
        cfg_vld = '0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (busy != '0 && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (busy != '0) begin
            note_error($sformatf("cores still busy after %0d cycles, busy=%h", limit, busy));
        end
        idle_cyc = cyc;
        @(posedge clk);
    endtask

    // Idle window, nothing may move
    task automatic check_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (busy != '0) begin
                note_error("busy is high with no job running");
            end
            if (map_rd.vld) begin
                note_error("map read strobe while idle");
            end
            for (int c = 0; c < `POOL_CORES; c++) begin
                if (ofm_rd[c].vld || ofm_wr[c].vld) begin
                    note_error($sformatf("core %0d feature strobe while idle", c));
                end
            end
        end
    endtask

    // Pulls this core's writes out of the capture queue and checks them in point order
    task automatic check_job_writes(input int core, input pool_cfg_t c);
        int       p;
        int       keep_core [$];
        idx_t     keep_addr [$];
        act_vec_t keep_vec  [$];
        p = 0;
        for (int i = 0; i < wr_core_q.size(); i++) begin
            if (wr_core_q[i] == core) begin
                if (p < int'(c.num_points)) begin
                    check_addr($sformatf("ofm_wr[%0d].addr", core), wr_addr_q[i],
                               c.out_base + idx_t'(p));
                    check_vec($sformatf("ofm_wr[%0d].vec", core), wr_vec_q[i], ref_max(c, p));
                end
                p++;
            end else begin
                keep_core.push_back(wr_core_q[i]);
                keep_addr.push_back(wr_addr_q[i]);
                keep_vec.push_back(wr_vec_q[i]);
            end
        end
        check_count($sformatf("ofm_wr[%0d] count", core), p, int'(c.num_points));
        wr_core_q = keep_core;
        wr_addr_q = keep_addr;
        wr_vec_q  = keep_vec;
    endtask

    task automatic check_no_stray();
        if (wr_core_q.size() != 0) begin
            note_error($sformatf("%0d output writes nobody asked for", wr_core_q.size()));
            wr_core_q.delete();
            wr_addr_q.delete();
            wr_vec_q.delete();
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic test_single_point();
        pool_cfg_t c;
        check_quiet(8);
        c = make_cfg(1, 4, 16, 'h100);
        start_job(2'b01, c, '0);
        wait_idle(500);
        check_job_writes(0, c);
        check_no_stray();
        end_test("reset and single point");
    endtask

    task automatic test_point_order();
        pool_cfg_t c;
        c = make_cfg(6, 8, 64, 'h200);
        start_job(2'b01, c, '0);
        wait_idle(2000);
        // busy drops the cycle after the last write
        check_count("busy fall cycle", idle_cyc, last_wr_cyc[0] + 1);
        check_job_writes(0, c);
        check_no_stray();
        end_test("six points in order");
    endtask

    task automatic test_two_cores();
        pool_cfg_t c0;
        pool_cfg_t c1;
        c0 = make_cfg(5, 6, 128, 'h300);
        c1 = make_cfg(7, 5, 192, 'h400);
        start_job(2'b11, c0, c1);
        wait_idle(3000);
        check_job_writes(0, c0);
        check_job_writes(1, c1);
        check_no_stray();
        end_test("two cores sharing the map bus");
    endtask

    task automatic test_k_one();
        pool_cfg_t c0;
        pool_cfg_t c1;
        // Core 1 copies single vectors, core 0 pairs the planted extremes
        c1 = make_cfg(6, 1, 512, 'h500);
        c0 = make_cfg(3, 2, 520, 'h510);
        start_job(2'b11, c0, c1);
        wait_idle(2000);
        check_job_writes(1, c1);
        check_job_writes(0, c0);
        check_no_stray();
        end_test("K=1 and unsigned extremes");
    endtask

    task automatic test_reconfig();
        pool_cfg_t ca;
        pool_cfg_t cb;
        ca = make_cfg(3, 3, 600, 'h600);
        cb = make_cfg(4, 16, 640, 'h640);
        start_job(2'b10, '0, ca);
        wait_idle(2000);
        check_job_writes(1, ca);
        check_no_stray();
        check_quiet(10);
        start_job(2'b10, '0, cb);
        wait_idle(3000);
        check_job_writes(1, cb);
        check_no_stray();
        end_test("reconfigure after busy falls");
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        for (int i = 0; i < 2**MAP_AW; i++) begin
            map_mem[i] = idx_t'(next_rand() >> 24);
        end
        for (int i = 0; i < 2**FEAT_AW; i++) begin
            feat_mem[i] = {next_rand(), next_rand()};
        end
        // Extremes, plus 0x80 against 0x7f which a signed compare gets wrong
        feat_mem[250] = {`POOL_LANES{8'hff}};
        feat_mem[251] = {`POOL_LANES{8'h00}};
        feat_mem[252] = {`POOL_LANES{8'h80}};
        feat_mem[253] = {`POOL_LANES{8'h7f}};
        map_mem[512]  = idx_t'(250);
        map_mem[513]  = idx_t'(251);
        map_mem[514]  = idx_t'(252);
        map_mem[515]  = idx_t'(253);
        map_mem[520]  = idx_t'(250);
        map_mem[521]  = idx_t'(251);
        map_mem[522]  = idx_t'(251);
        map_mem[523]  = idx_t'(250);
        map_mem[524]  = idx_t'(252);
        map_mem[525]  = idx_t'(253);

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_single_point();
        test_point_order();
        test_two_cores();
        test_k_one();
        test_reconfig();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/pool_top.sv */
// Top of the max-pooling engine
// POOL_CORES cores share one map-read bus through the arbiter
`timescale 1ns/1ps
`include "pool_consts.svh"

module pool_top import pool_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Per-core job setup
    input  logic [`POOL_CORES-1:0] cfg_vld,
    input  pool_cfg_t              cfg [`POOL_CORES],
    output logic [`POOL_CORES-1:0] busy,
    // Shared neighbor-map memory
    output map_req_t               map_rd,
    input  map_rsp_t               map_rsp,
    // Per-core feature ports
    output ofm_req_t               ofm_rd [`POOL_CORES],
    input  ofm_rsp_t               ofm_rsp [`POOL_CORES],
    output ofm_wr_t                ofm_wr [`POOL_CORES]
);

    // ======================================================================
    // Core to arbiter wiring
    // ======================================================================
    map_req_t               core_map_req [`POOL_CORES];
    map_rsp_t               core_map_rsp [`POOL_CORES];
    logic [`POOL_CORES-1:0] core_map_gnt;

    map_arbiter u_map_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_req (core_map_req),
        .map_gnt  (core_map_gnt),
        .map_rd   (map_rd),
        .map_rsp  (map_rsp),
        .core_rsp (core_map_rsp)
    );

    // ======================================================================
    // Pool cores
    // ======================================================================
    // Core 0 has top map priority
    for (genvar c = 0; c < `POOL_CORES; c++) begin : g_core
        pool_core u_pool_core (
            .clk     (clk),
            .rst_n   (rst_n),
            .cfg_vld (cfg_vld[c]),
            .cfg     (cfg[c]),
            .busy    (busy[c]),
            .map_req (core_map_req[c]),
            .map_gnt (core_map_gnt[c]),
            .map_rsp (core_map_rsp[c]),
            .ofm_rd  (ofm_rd[c]),
            .ofm_rsp (ofm_rsp[c]),
            .ofm_wr  (ofm_wr[c])
        );
    end

endmodule

/* hdl/pool_core.sv */
// One pooling core: walks points and neighbors for a job
// Fetches indices over the shared map bus, then features, then writes the max
`timescale 1ns/1ps
`include "pool_consts.svh"

module pool_core import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_vld,
    input  pool_cfg_t cfg,
    output logic      busy,
    output map_req_t  map_req,
    input  logic      map_gnt,
    input  map_rsp_t  map_rsp,
    output ofm_req_t  ofm_rd,
    input  ofm_rsp_t  ofm_rsp,
    output ofm_wr_t   ofm_wr
);

    localparam int CNT_W = $clog2(`IDX_FIFO_DEPTH + 1);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t              state;
    pool_cfg_t           cfg_q;
    logic                cfg_take;
    logic [`K_W-1:0]     k_last;
    logic [`POINT_W-1:0] pt_last;

    // Issue side
    logic [`POINT_W-1:0] iss_pt;
    logic [`K_W-1:0]     iss_nb;
    logic [`IDX_W-1:0]   iss_addr;
    logic                iss_last;
    logic                iss_done;
    logic [CNT_W-1:0]    map_pend;
    logic [CNT_W-1:0]    fifo_cnt;
    logic [CNT_W:0]      credit_used;

    // Consume side
    logic [`IDX_W-1:0]   idx_head;
    logic                idx_empty;
    logic                rd_fire;
    logic                rd_pend;
    logic [`POINT_W-1:0] cons_pt;
    logic [`K_W-1:0]     cons_nb;
    logic                cons_first;
    logic                cons_last;
    logic [`IDX_W-1:0]   wr_addr;

    // ======================================================================
    // Job control
    // ======================================================================
    assign cfg_take = cfg_vld && !busy;
    assign busy     = (state == ST_RUN);
    assign k_last   = cfg_q.k - 1'b1;
    assign pt_last  = cfg_q.num_points - 1'b1;

    // Done once the final point's write leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (cfg_take) begin
            state <= ST_RUN;
        end else if (ofm_wr.vld && (cons_pt == cfg_q.num_points)) begin
            state <= ST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_take) begin
            cfg_q <= cfg;
        end
    end

    // ======================================================================
    // Map issue
    // ======================================================================
    // Neighbor-minor order, so the map address simply counts up
    assign iss_last    = (iss_pt == pt_last) && (iss_nb == k_last);
    // Reads in flight plus indices parked in the queue
    assign credit_used = map_pend + fifo_cnt;

    always_comb begin
        map_req.vld  = busy && !iss_done && (credit_used < `IDX_FIFO_DEPTH);
        map_req.addr = iss_addr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_pt   <= '0;
            iss_nb   <= '0;
            iss_done <= 1'b0;
        end else if (cfg_take) begin
            iss_pt   <= '0;
            iss_nb   <= '0;
            iss_done <= 1'b0;
        end else if (map_gnt) begin
            if (iss_last) begin
                iss_done <= 1'b1;
            end
            if (iss_nb == k_last) begin
                iss_nb <= '0;
                iss_pt <= iss_pt + 1'b1;
            end else begin
                iss_nb <= iss_nb + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_take) begin
            iss_addr <= cfg.map_base;
        end else if (map_gnt) begin
            iss_addr <= iss_addr + 1'b1;
        end
    end

    // Granted but unanswered map reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_pend <= '0;
        end else begin
            case ({map_gnt, map_rsp.vld})
                2'b10:   map_pend <= map_pend + 1'b1;
                2'b01:   map_pend <= map_pend - 1'b1;
                default: map_pend <= map_pend;
            endcase
        end
    end

    // ======================================================================
    // Index queue and feature reads
    // ======================================================================
    strobe_fifo #(
        .T     (logic [`IDX_W-1:0]),
        .DEPTH (`IDX_FIFO_DEPTH)
    ) u_idx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (map_rsp.vld),
        .din   (map_rsp.idx),
        .pop   (rd_fire),
        .dout  (idx_head),
        .empty (idx_empty),
        .count (fifo_cnt)
    );

    // Single feature read in flight
    assign rd_fire = busy && !idx_empty && !rd_pend;

    always_comb begin
        ofm_rd.vld  = rd_fire;
        ofm_rd.addr = idx_head;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else if (rd_fire) begin
            rd_pend <= 1'b1;
        end else if (ofm_rsp.vld) begin
            rd_pend <= 1'b0;
        end
    end

    // ======================================================================
    // Consume counters and max
    // ======================================================================
    assign cons_first = (cons_nb == '0);
    assign cons_last  = (cons_nb == k_last);
    assign wr_addr    = cfg_q.out_base + cons_pt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cons_pt <= '0;
            cons_nb <= '0;
        end else if (cfg_take) begin
            cons_pt <= '0;
            cons_nb <= '0;
        end else if (ofm_rsp.vld) begin
            if (cons_last) begin
                cons_nb <= '0;
                cons_pt <= cons_pt + 1'b1;
            end else begin
                cons_nb <= cons_nb + 1'b1;
            end
        end
    end

    max_accum u_max_accum (
        .clk     (clk),
        .rst_n   (rst_n),
        .vec_vld (ofm_rsp.vld),
        .vec     (ofm_rsp.vec),
        .first   (cons_first),
        .last    (cons_last),
        .wr_addr (wr_addr),
        .ofm_wr  (ofm_wr)
    );

    // New job only while idle
    a_cfg_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_vld |-> !busy);
    // Feature memory answers only the read we issued
    a_ofm_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_rsp.vld |-> rd_pend);

endmodule

/* hdl/max_accum.sv */
// Lane-wise running maximum over the neighbors of one point
// Emits the output write one cycle after the last neighbor
`timescale 1ns/1ps
`include "pool_consts.svh"

module max_accum import pool_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              vec_vld,
    input  act_vec_t          vec,
    input  logic              first,
    input  logic              last,
    input  logic [`IDX_W-1:0] wr_addr,
    output ofm_wr_t           ofm_wr
);

    act_vec_t          acc;
    act_vec_t          acc_next;
    logic              wr_vld;
    logic [`IDX_W-1:0] wr_addr_q;
    act_vec_t          wr_vec_q;

    // Unsigned compare per lane
    // First neighbor overwrites, old contents don't matter
    always_comb begin
        for (int l = 0; l < `POOL_LANES; l++) begin
            if (first || (vec[l] > acc[l])) begin
                acc_next[l] = vec[l];
            end else begin
                acc_next[l] = acc[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vec_vld) begin
            acc <= acc_next;
        end
    end

    // Write strobe, one cycle after the K-th vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_vld <= 1'b0;
        end else begin
            wr_vld <= vec_vld && last;
        end
    end

    // Finished max and its address ride with the strobe
    always_ff @(posedge clk) begin
        if (vec_vld && last) begin
            wr_addr_q <= wr_addr;
            wr_vec_q  <= acc_next;
        end
    end

    always_comb begin
        ofm_wr.vld  = wr_vld;
        ofm_wr.addr = wr_addr_q;
        ofm_wr.vec  = wr_vec_q;
    end

endmodule

/* hdl/map_arbiter.sv */
// Fixed-priority arbiter for the shared neighbor-map read bus
// Lowest core wins, tag queue steers in-order responses back
`timescale 1ns/1ps
`include "pool_consts.svh"

module map_arbiter import pool_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  map_req_t               core_req [`POOL_CORES],
    output logic [`POOL_CORES-1:0] map_gnt,
    output map_req_t               map_rd,
    input  map_rsp_t               map_rsp,
    output map_rsp_t               core_rsp [`POOL_CORES]
);

    // Winner of this cycle
    core_id_t win;
    logic     found;
    // Owner of the oldest outstanding read
    core_id_t tag_head;

    // ======================================================================
    // Request side
    // ======================================================================
    // Scan upward, first pending core takes the bus
    always_comb begin
        map_gnt = '0;
        win     = '0;
        found   = 1'b0;
        for (int i = 0; i < `POOL_CORES; i++) begin
            if (core_req[i].vld && !found) begin
                map_gnt[i] = 1'b1;
                win        = core_id_t'(i);
                found      = 1'b1;
            end
        end
    end

    // Granted request goes straight out as a strobe
    always_comb begin
        map_rd.vld  = found;
        map_rd.addr = core_req[win].addr;
    end

    // ======================================================================
    // Tag queue
    // ======================================================================
    // One tag per issued read, popped as its answer returns
    strobe_fifo #(
        .T     (core_id_t),
        .DEPTH (`MAP_OUTSTANDING)
    ) u_tag_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (map_rd.vld),
        .din   (win),
        .pop   (map_rsp.vld),
        .dout  (tag_head),
        .empty (),
        .count ()
    );

    // ======================================================================
    // Response side
    // ======================================================================
    // Memory answers in order, so the head tag names the owner
    always_comb begin
        for (int i = 0; i < `POOL_CORES; i++) begin
            core_rsp[i].vld = map_rsp.vld && (tag_head == core_id_t'(i));
            // Index fans out to all, only the owner sees vld
            core_rsp[i].idx = map_rsp.idx;
        end
    end

endmodule

/* hdl/strobe_fifo.sv */
// Small circular queue, head readable without a pop
// Payload type set per instance, strobed push and pop
`timescale 1ns/1ps

module strobe_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  T                             din,
    input  logic                         pop,
    output T                             dout,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             full;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // Storage, payload only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Net fill change
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign dout  = mem[rd_ptr];
    assign empty = (fill == '0);
    assign full  = (fill == CNT_W'(DEPTH));
    assign count = fill;

    // Credit or tag accounting upstream must keep these from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push && !pop |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

/* hdl/pool_pkg.sv */
// Shared struct types for the pooling engine
// Import into modules that carry config, bus requests or vectors
`include "pool_consts.svh"

package pool_pkg;

    // One feature vector, lane 0 in the low byte
    typedef logic [`POOL_LANES-1:0][`ACT_W-1:0] act_vec_t;

    // Core tag for response routing
    typedef logic [`CORE_ID_W-1:0] core_id_t;

    // Job descriptor, 53 bits
    typedef struct packed {
        logic [`POINT_W-1:0] num_points;
        logic [`K_W-1:0]     k;
        logic [`IDX_W-1:0]   map_base;
        logic [`IDX_W-1:0]   out_base;
    } pool_cfg_t;

    // Map read request and index response
    typedef struct packed {
        logic              vld;
        logic [`IDX_W-1:0] addr;
    } map_req_t;

    typedef struct packed {
        logic              vld;
        logic [`IDX_W-1:0] idx;
    } map_rsp_t;

    // Feature read, response and output write
    typedef struct packed {
        logic              vld;
        logic [`IDX_W-1:0] addr;
    } ofm_req_t;

    typedef struct packed {
        logic     vld;
        act_vec_t vec;
    } ofm_rsp_t;

    typedef struct packed {
        logic              vld;
        logic [`IDX_W-1:0] addr;
        act_vec_t          vec;
    } ofm_wr_t;

endpackage

/* hdl/pool_consts.svh */
// Size constants for the point-cloud max-pooling engine
// Include wherever lane counts, widths or queue depths are needed
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// ==========================================================================
// Datapath sizes
// ==========================================================================
// Activation lanes per feature vector
`define POOL_LANES      8
// Bits per activation, unsigned
`define ACT_W           8
// Map and feature address width
`define IDX_W           16
// Point counter width
`define POINT_W         16
// Neighbor count width, K runs 1..16
`define K_W             5

// ==========================================================================
// Core count and queue depths
// ==========================================================================
`define POOL_CORES      2
`define CORE_ID_W       1
// Index queue per core, also its map credit limit
`define IDX_FIFO_DEPTH  4
// Tag queue in the arbiter
`define MAP_OUTSTANDING 8

`endif
